// ==== zb_config.svh ====
`ifndef ZB_CONFIG_SVH
`define ZB_CONFIG_SVH

// tile geometry
`define ZB_TILE_DIM 32 // pixels along one tile edge
`define ZB_ROW_BITS 5 // index width for row or column

// stored word layout
`define ZB_DEPTH_BITS 32 // unsigned depth word
`define ZB_TAG_BITS 9 // primitive id kept beside the depth

// values written by a tile clear
// all zero depth means every later compare sees the nearest surface
`define ZB_CLEAR_DEPTH {`ZB_DEPTH_BITS{1'b0}}
`define ZB_CLEAR_TAG {`ZB_TAG_BITS{1'b0}}

`endif

// ==== zb_pkg.sv ====
`include "zb_config.svh"

package zb_pkg;

	// depth test modes, encoding matches the 3-bit mode field of a row write
	// each mode tests candidate against stored, both unsigned
	typedef enum logic [2:0] {
		mode_never = 3'd0, // never passes
		mode_less = 3'd1, // new < old
		mode_equal = 3'd2, // new == old
		mode_less_equal = 3'd3, // new <= old
		mode_greater = 3'd4, // new > old
		mode_not_equal = 3'd5, // new != old
		mode_greater_equal = 3'd6, // new >= old
		mode_always = 3'd7 // always passes
	} depth_mode_e;

	// tile clear walker states
	typedef enum logic {
		clear_idle = 1'b0, // no clear running
		clear_run = 1'b1 // one row per cycle
	} clear_state_e;

	// one stored word, tag in the upper bits
	typedef struct packed {
		logic [`ZB_TAG_BITS-1:0] tag; // primitive tag
		logic [`ZB_DEPTH_BITS-1:0] depth; // depth value
	} zb_entry_t;

	// everything one row write carries
	typedef struct packed {
		logic [`ZB_TILE_DIM-1:0] mask; // coverage, bit i for column i
		depth_mode_e mode; // depth test for this primitive
		logic [`ZB_TAG_BITS-1:0] tag; // same tag for whole row
		logic [`ZB_TILE_DIM-1:0][`ZB_DEPTH_BITS-1:0] depth; // one candidate per column
	} zb_row_write_t;

endpackage

// ==== depth_compare.sv ====
`include "zb_config.svh"

module depth_compare (
	input zb_pkg::depth_mode_e mode, // test selected by the primitive
	input logic [`ZB_DEPTH_BITS-1:0] new_depth, // candidate from the rasterizer
	input logic [`ZB_DEPTH_BITS-1:0] old_depth, // word already in the buffer
	output logic pass // candidate may replace stored word
);

	always_comb begin
		case (mode)
			zb_pkg::mode_never: begin
				pass = 1'b0;
			end
			zb_pkg::mode_less: begin
				pass = (new_depth < old_depth);
			end
			zb_pkg::mode_equal: begin
				pass = (new_depth == old_depth);
			end
			zb_pkg::mode_less_equal: begin
				pass = (new_depth <= old_depth);
			end
			zb_pkg::mode_greater: begin
				pass = (new_depth > old_depth);
			end
			zb_pkg::mode_not_equal: begin
				pass = (new_depth != old_depth);
			end
			zb_pkg::mode_greater_equal: begin
				pass = (new_depth >= old_depth);
			end
			zb_pkg::mode_always: begin
				pass = 1'b1;
			end
			default: begin
				pass = 1'b0; // unreachable with a full 3-bit enum
			end
		endcase
	end

endmodule

// ==== z_column_ram.sv ====
`include "zb_config.svh"

module z_column_ram (
	input logic clock,
	input logic [`ZB_ROW_BITS-1:0] addr, // row within the tile
	input logic wr_en, // store wr_data at addr
	input zb_pkg::zb_entry_t wr_data, // tag and depth to store
	output zb_pkg::zb_entry_t rd_data // word at addr of previous edge
);

	// one word per tile row of this column
	zb_pkg::zb_entry_t mem [`ZB_TILE_DIM];

	// single port read-before-write ram
	// maps onto one block ram per column
	always_ff @(posedge clock) begin
		if (wr_en) begin
			mem[addr] <= wr_data; // new word seen on a later read
		end
		rd_data <= mem[addr]; // old word if same-cycle write
	end

endmodule

// ==== z_column.sv ====
`include "zb_config.svh"

module z_column (
	input logic clock,
	input logic busy, // tile clear in progress
	input logic [`ZB_ROW_BITS-1:0] row_addr, // clear row or user row
	input logic write_trig, // row write strobe
	input logic covered, // this column's mask bit
	input zb_pkg::depth_mode_e mode, // depth test
	input logic [`ZB_TAG_BITS-1:0] tag, // primitive tag
	input logic [`ZB_DEPTH_BITS-1:0] depth, // candidate depth
	output zb_pkg::zb_entry_t stored // registered word of row_addr
);

	logic pass; // candidate wins the depth test
	logic wr_en; // ram write this cycle
	zb_pkg::zb_entry_t wr_data; // ram write word

	// stored already holds the row picked one cycle earlier
	// so the test runs on the old word of the row being written
	depth_compare i_depth_compare (
		.mode(mode),
		.new_depth(depth),
		.old_depth(stored.depth),
		.pass(pass)
	);

	// clear overrides mask and mode
	// a trigger during a clear just lands on the clear write
	assign wr_en = busy | (write_trig & covered & pass);

	always_comb begin
		if (busy) begin
			wr_data.tag = `ZB_CLEAR_TAG; // zero tag
			wr_data.depth = `ZB_CLEAR_DEPTH; // clear depth
		end else begin
			wr_data.tag = tag;
			wr_data.depth = depth;
		end
	end

	z_column_ram i_z_column_ram (
		.clock(clock),
		.addr(row_addr),
		.wr_en(wr_en),
		.wr_data(wr_data),
		.rd_data(stored)
	);

endmodule

// ==== tile_clear_fsm.sv ====
`include "zb_config.svh"

module tile_clear_fsm (
	input logic clock,
	input logic reset_n,
	input logic clear_z, // one-cycle request from the tile sequencer
	output logic busy, // high while rows are being cleared
	output logic [`ZB_ROW_BITS-1:0] clear_row // row cleared this cycle
);

	localparam logic [`ZB_ROW_BITS-1:0] last_row = `ZB_ROW_BITS'(`ZB_TILE_DIM - 1);

	zb_pkg::clear_state_e state; // current state
	zb_pkg::clear_state_e state_next; // next state
	logic [`ZB_ROW_BITS-1:0] row_next; // next clear row

	// requests while running are dropped
	always_comb begin
		state_next = state;
		row_next = clear_row;
		case (state)
			zb_pkg::clear_idle: begin
				if (clear_z) begin
					state_next = zb_pkg::clear_run;
					row_next = '0; // start at top row
				end
			end
			zb_pkg::clear_run: begin
				if (clear_row == last_row) begin
					state_next = zb_pkg::clear_idle; // last row written this edge
				end else begin
					row_next = clear_row + 1'b1;
				end
			end
			default: begin
				state_next = zb_pkg::clear_idle;
			end
		endcase
	end

	always_ff @(posedge clock or negedge reset_n) begin
		if (!reset_n) begin
			state <= zb_pkg::clear_idle;
			clear_row <= '0;
		end else begin
			state <= state_next;
			clear_row <= row_next;
		end
	end

	// one row per cycle in run state, so 32 cycles high
	assign busy = (state == zb_pkg::clear_run);

endmodule

// ==== z_buffer.sv ====
`include "zb_config.svh"

module z_buffer (
	input logic clock,
	input logic reset_n,

	// tile clear
	input logic clear_z, // one-cycle clear request
	output logic clear_busy, // clear walking the rows

	// pixel addressing
	input logic [`ZB_ROW_BITS-1:0] row_sel, // tile row, y
	input logic [`ZB_ROW_BITS-1:0] col_sel, // tile column, x

	// row write
	input zb_pkg::zb_row_write_t row_write, // mask, mode, tag and 32 depths
	input logic write_trig, // hold row_sel one cycle before this

	// readback
	output zb_pkg::zb_entry_t pixel // word at last row_sel, current col_sel
);

	logic busy; // clear fsm running
	logic [`ZB_ROW_BITS-1:0] clear_row; // row the fsm clears now
	logic [`ZB_ROW_BITS-1:0] row_addr; // shared address to all columns

	// registered ram outputs, one word per column
	zb_pkg::zb_entry_t col_out [`ZB_TILE_DIM];

	// clear sequencer
	tile_clear_fsm i_tile_clear_fsm (
		.clock(clock),
		.reset_n(reset_n),
		.clear_z(clear_z),
		.busy(busy),
		.clear_row(clear_row)
	);

	assign clear_busy = busy;

	// clear owns the address while busy
	// user row_sel has no effect until busy drops
	assign row_addr = busy ? clear_row : row_sel;

	// column array
	// column i gets mask bit i and depth word i of the row write
	// mode and tag are shared across the row
	for (genvar i = 0; i < `ZB_TILE_DIM; i++) begin : g_col
		z_column i_z_column (
			.clock(clock),
			.busy(busy),
			.row_addr(row_addr),
			.write_trig(write_trig),
			.covered(row_write.mask[i]),
			.mode(row_write.mode),
			.tag(row_write.tag),
			.depth(row_write.depth[i]),
			.stored(col_out[i])
		);
	end

	// pixel readback
	// row already chosen by the ram read register
	// col_sel is live, so changing it needs no extra cycle
	assign pixel = col_out[col_sel];

endmodule

// ==== tb_z_buffer.sv ====
`include "zb_config.svh"

module tb_z_buffer;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int dim = `ZB_TILE_DIM;
	localparam int op_clear = 0; // tile clear with busy cycle count
	localparam int op_write = 1; // two-cycle row write
	localparam int op_read = 2; // pixel readback
	localparam int dsel_rand = 0; // target column keeps its random candidate
	localparam int dsel_below = 1; // candidate one under stored
	localparam int dsel_equal = 2; // candidate equal to stored
	localparam int dsel_above = 3; // candidate one over stored
	localparam int all_rows = dim; // row field for a whole-tile read
	localparam int max_tests = 40;
	localparam int busy_timeout = 100; // cycles allowed for one clear

	logic clock;
	logic reset_n;
	logic clear_z;
	logic clear_busy;
	logic [`ZB_ROW_BITS-1:0] row_sel;
	logic [`ZB_ROW_BITS-1:0] col_sel;
	zb_pkg::zb_row_write_t row_write;
	logic write_trig;
	zb_pkg::zb_entry_t pixel;

	// stimulus table
	string names [max_tests];
	int ops [max_tests];
	int rows [max_tests];
	int cols [max_tests]; // column whose update is predicted
	logic [dim-1:0] masks [max_tests]; // nonzero on a clear pulses write_trig while busy
	zb_pkg::depth_mode_e modes [max_tests];
	logic [`ZB_TAG_BITS-1:0] tags [max_tests];
	int dsels [max_tests]; // depth seed selector
	int exps [max_tests]; // busy cycles, target update, or all clear

	int n_tests;

	// reference model of the tile by row and column
	zb_pkg::zb_entry_t model [dim][dim];
	zb_pkg::zb_entry_t clear_word;

	integer seed;
	int test_errs;
	int passed;
	int failed;
	bit timed_out;
	string rel_name [3];
	logic [2:0] update_on [8]; // bit 0 below, bit 1 equal, bit 2 above
	zb_pkg::depth_mode_e mode_v;

	z_buffer i_z_buffer (
		.clock(clock),
		.reset_n(reset_n),
		.clear_z(clear_z),
		.clear_busy(clear_busy),
		.row_sel(row_sel),
		.col_sel(col_sel),
		.row_write(row_write),
		.write_trig(write_trig),
		.pixel(pixel)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock; // 20 ns period
	end

	// depth test from the outcome of an unsigned compare
	function automatic bit candidate_wins(input logic [2:0] mode,
			input logic [`ZB_DEPTH_BITS-1:0] cand, input logic [`ZB_DEPTH_BITS-1:0] stored);
		return (mode[0] && (cand < stored)) || (mode[1] && (cand == stored)) ||
			(mode[2] && (cand > stored));
	endfunction

	task automatic add_test(input string name, input int op, input int row, input int col,
			input logic [dim-1:0] mask, input zb_pkg::depth_mode_e mode,
			input logic [`ZB_TAG_BITS-1:0] tag, input int dsel, input int exp_val);
		names[n_tests] = name;
		ops[n_tests] = op;
		rows[n_tests] = row;
		cols[n_tests] = col;
		masks[n_tests] = mask;
		modes[n_tests] = mode;
		tags[n_tests] = tag;
		dsels[n_tests] = dsel;
		exps[n_tests] = exp_val;
		n_tests++;
	endtask

	// read the selected columns of one row against the model
	task automatic check_row(input int k, input int r, input logic [dim-1:0] sel,
			input bit want_clear);
		@(posedge clock);
		row_sel <= `ZB_ROW_BITS'(r);
		@(posedge clock); // ram latches row r
		for (int i = 0; i < dim; i++) begin
			if (sel[i]) begin
				col_sel <= `ZB_ROW_BITS'(i); // column mux is combinational
				@(negedge clock);
				assert (pixel === model[r][i]) else begin
					$display("mismatch %s: pixel (%0d,%0d) expected %h, actual %h",
						names[k], r, i, model[r][i], pixel);
					test_errs++;
				end
				if (want_clear) begin
					assert (pixel === clear_word) else begin
						$display("mismatch %s: pixel (%0d,%0d) expected %h, actual %h",
							names[k], r, i, clear_word, pixel);
						test_errs++;
					end
				end
				@(posedge clock);
			end
		end
	endtask

	task automatic run_clear(input int k);
		zb_pkg::zb_row_write_t noise;
		int cycles;
		int waited;
		cycles = 0;
		waited = 0;
		@(posedge clock);
		clear_z <= 1'b1;
		@(negedge clock);
		assert (clear_busy === 1'b0) else begin
			$display("test %s: clear_busy rose in the same cycle as clear_z", names[k]);
			test_errs++;
		end
		@(posedge clock); // fsm takes the request here
		clear_z <= 1'b0;
		@(negedge clock);
		assert (clear_busy === 1'b1) else begin
			$display("test %s: clear_busy did not rise on the edge after clear_z", names[k]);
			test_errs++;
		end
		while (clear_busy === 1'b1 && waited < busy_timeout) begin
			cycles++;
			@(posedge clock);
			if (masks[k] != 0 && cycles < dim) begin
				noise.mask = '1; // every column would write
				noise.mode = zb_pkg::mode_always;
				noise.tag = $random(seed);
				for (int i = 0; i < dim; i++) begin
					noise.depth[i] = $random(seed);
				end
				row_write <= noise;
				row_sel <= `ZB_ROW_BITS'($random(seed));
				write_trig <= cycles[0]; // pulse every other cycle
			end else begin
				write_trig <= 1'b0; // quiet once the clear is about to end
			end
			@(negedge clock);
			waited++;
		end
		if (clear_busy === 1'b1) begin
			$display("test %s: clear never finished, clear_busy still high after %0d cycles",
				names[k], busy_timeout);
			timed_out = 1'b1;
			test_errs++;
		end else begin
			assert (cycles == exps[k]) else begin
				$display("mismatch %s: busy cycles expected %0d, actual %0d",
					names[k], exps[k], cycles);
				test_errs++;
			end
		end
		for (int r = 0; r < dim; r++) begin
			for (int c = 0; c < dim; c++) begin
				model[r][c] = clear_word;
			end
		end
	endtask

	task automatic run_write(input int k);
		zb_pkg::zb_row_write_t wr;
		logic [`ZB_DEPTH_BITS-1:0] old_depth;
		int r;
		int c;
		bit hit;
		r = rows[k];
		c = cols[k];
		hit = 1'b0;
		wr.mask = masks[k];
		wr.mode = modes[k];
		wr.tag = tags[k];
		for (int i = 0; i < dim; i++) begin
			wr.depth[i] = $random(seed);
		end
		old_depth = model[r][c].depth;
		case (dsels[k])
			dsel_below: wr.depth[c] = old_depth - 1'b1;
			dsel_equal: wr.depth[c] = old_depth;
			dsel_above: wr.depth[c] = old_depth + 1'b1;
			default: wr.depth[c] = wr.depth[c]; // random candidate
		endcase
		// each column tests against its own stored word
		for (int i = 0; i < dim; i++) begin
			if (wr.mask[i] && candidate_wins(wr.mode, wr.depth[i], model[r][i].depth)) begin
				model[r][i].tag = wr.tag;
				model[r][i].depth = wr.depth[i];
				if (i == c) begin
					hit = 1'b1;
				end
			end
		end
		assert (hit == (exps[k] != 0)) else begin
			$display("mismatch %s: target update expected %0d, actual %0d",
				names[k], exps[k], hit);
			test_errs++;
		end
		@(posedge clock);
		row_sel <= `ZB_ROW_BITS'(r);
		@(posedge clock); // stored row now on the ram output
		row_write <= wr;
		write_trig <= 1'b1;
		@(posedge clock); // compare result written here
		write_trig <= 1'b0;
		check_row(k, r, '1, 1'b0);
	endtask

	task automatic run_read(input int k);
		for (int r = 0; r < dim; r++) begin
			if (rows[k] == all_rows || rows[k] == r) begin
				check_row(k, r, masks[k], exps[k] != 0);
			end
		end
	endtask

	initial begin
		seed = 88426;
		reset_n = 1'b0;
		clear_z = 1'b0;
		row_sel = '0;
		col_sel = '0;
		row_write = '0;
		write_trig = 1'b0;
		n_tests = 0;
		passed = 0;
		failed = 0;
		timed_out = 1'b0;
		clear_word.tag = `ZB_CLEAR_TAG;
		clear_word.depth = `ZB_CLEAR_DEPTH;
		rel_name = '{"below", "equal", "above"};
		// never, less, equal, less_equal, greater, not_equal, greater_equal, always
		update_on = '{3'b000, 3'b001, 3'b010, 3'b011, 3'b100, 3'b101, 3'b110, 3'b111};

		add_test("tile_clear", op_clear, 0, 0, '0, zb_pkg::mode_never, '0, dsel_rand, 32);
		add_test("clear_readback", op_read, all_rows, 0, '1, zb_pkg::mode_never, '0,
			dsel_rand, 1);
		add_test("full_row_always_r5", op_write, 5, 0, '1, zb_pkg::mode_always, 9'h1a5,
			dsel_rand, 1);
		add_test("full_row_always_r17", op_write, 17, 0, '1, zb_pkg::mode_always, 9'h03c,
			dsel_rand, 1);
		add_test("partial_mask_covered", op_write, 5, 3, 32'h0000_f0f8,
			zb_pkg::mode_always, 9'h0ee, dsel_rand, 1);
		add_test("partial_mask_uncovered", op_write, 5, 2, 32'h8000_0000,
			zb_pkg::mode_always, 9'h111, dsel_rand, 0);
		add_test("partial_mask_readback", op_read, 5, 0, '1, zb_pkg::mode_never, '0,
			dsel_rand, 0);
		for (int m = 0; m < 8; m++) begin
			for (int d = 0; d < 3; d++) begin
				mode_v = zb_pkg::depth_mode_e'(m);
				add_test($sformatf("mode_%s_%s", mode_v.name(), rel_name[d]), op_write,
					17, 9, '1, mode_v, 16 + 3 * m + d, d + 1, update_on[m][d]);
			end
		end
		add_test("row_fill_r30", op_write, 30, 0, '1, zb_pkg::mode_always, 9'h1ff,
			dsel_rand, 1);
		add_test("clear_with_trig", op_clear, 0, 0, '1, zb_pkg::mode_never, '0,
			dsel_rand, 32);
		add_test("clear_after_trig_readback", op_read, all_rows, 0, '1,
			zb_pkg::mode_never, '0, dsel_rand, 1);

		repeat (4) @(posedge clock);
		reset_n <= 1'b1;

		for (int k = 0; k < n_tests && !timed_out; k++) begin
			test_errs = 0;
			case (ops[k])
				op_clear: run_clear(k);
				op_write: run_write(k);
				default: run_read(k);
			endcase
			if (test_errs == 0) begin
				$display("test %0d %s: ok", k, names[k]);
				passed++;
			end else begin
				$display("test %0d %s: failed with %0d errors", k, names[k], test_errs);
				failed++;
			end
		end

		$display("%0d tests passed, %0d tests failed", passed, failed);
		if (failed == 0 && !timed_out) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

// ==== flist.f ====
+incdir+.
zb_pkg.sv
depth_compare.sv
z_column_ram.sv
z_column.sv
tile_clear_fsm.sv
z_buffer.sv
tb_z_buffer.sv

// ==== Bender.yml ====
package:
  name: z_buffer

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - zb_pkg.sv
      - depth_compare.sv
      - z_column_ram.sv
      - z_column.sv
      - tile_clear_fsm.sv
      - z_buffer.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_z_buffer.sv
